// ==== common/router_defines.svh ====
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// Number of input ports.
`define ROUTER_PORTS 5

// Flit payload width.
`define ROUTER_DATA_W 16

// Packet length field, counted in flits.
`define ROUTER_LEN_W 12

// Default depth of each input buffer.
`define ROUTER_FIFO_DEPTH 4

`endif

// ==== common/routerPkg.sv ====
`default_nettype none

package routerPkg;

  `include "router_defines.svh"

  // Only HEAD is decoded by the RTL.
  typedef enum logic [2:0] {
    HEAD = 3'd1,
    BODY = 3'd2,
    TAIL = 3'd3
  } flitKind_t;

  typedef struct packed {
    flitKind_t                 flitKind;
    logic [`ROUTER_LEN_W-1:0]  length;  // Flits incl. header.
    logic [`ROUTER_DATA_W-1:0] data;
  } flit_t;

  // 0 Local, 1 North, 2 East, 3 West, 4 South.
  typedef logic [2:0] portIdx_t;

endpackage

`default_nettype wire

// ==== rtl/flitFifo.sv ====
`default_nettype none

`include "router_defines.svh"

module flitFifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `ROUTER_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t inData,
  input  logic     inValid,
  output logic     inReady,
  output payload_t outData,
  output logic     outValid,
  input  logic     outReady
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] rdPtrNext;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             full;

  function automatic logic [PTR_W-1:0] ptrInc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (count == CNT_W'(DEPTH));
  assign inReady   = !full || outReady;  // Full buffer still takes a flit while the head leaves.
  assign push      = inValid && inReady;
  assign pop       = outValid && outReady;
  assign outValid  = (count != '0);
  assign rdPtrNext = pop ? ptrInc(rdPtr) : rdPtr;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= ptrInc(wrPtr);
      rdPtr <= rdPtrNext;
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inData;
    // Registered head, bypassed when the incoming flit becomes the head.
    if (push && (count == CNT_W'(pop)))
      outData <= inData;
    else
      outData <= mem[rdPtrNext];
  end

endmodule

`default_nettype wire

// ==== arbiter/grantTimer.sv ====
`default_nettype none

`include "router_defines.svh"

module grantTimer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     load,
  input  logic [`ROUTER_LEN_W-1:0] length,
  input  logic                     step,
  output logic                     lastFlit
);

  logic [`ROUTER_LEN_W-1:0] packetLen;
  logic [`ROUTER_LEN_W-1:0] sent;      // Flits already moved.
  logic                     headIsLast;

  // One-flit packet, or zero length, ends on its header.
  assign headIsLast = (length <= `ROUTER_LEN_W'(1));
  assign lastFlit   = step && (load ? headIsLast : ((sent + 1'b1) == packetLen));

  always_ff @(posedge clk)
  begin
    if (load)
      packetLen <= headIsLast ? `ROUTER_LEN_W'(1) : length;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      sent <= '0;
    else if (step)
    begin
      if (lastFlit)
        sent <= '0;
      else if (load)
        sent <= `ROUTER_LEN_W'(1);
      else
        sent <= sent + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== arbiter/packetArbiter.sv ====
`default_nettype none

`include "router_defines.svh"

module packetArbiter (
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::flit_t         headFlit [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0] headValid,
  input  logic [`ROUTER_PORTS-1:0] headReady,
  output logic                     grantValid,
  output routerPkg::portIdx_t      grantPort
);

  import routerPkg::*;

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arbState_t;

  arbState_t                state;
  portIdx_t                 lastServed;
  logic [`ROUTER_PORTS-1:0] xfer;
  logic [`ROUTER_PORTS-1:0] isHead;
  logic [`ROUTER_PORTS-1:0] lastFlit;
  logic                     packetDone;
  logic                     found;
  portIdx_t                 pick;

  assign grantValid = (state == ARB_BUSY);
  assign grantPort  = lastServed;  // Current owner while busy.

  for (genvar p = 0; p < `ROUTER_PORTS; p++)
  begin : genPort
    assign xfer[p] = grantValid && (grantPort == portIdx_t'(p)) &&
                     headValid[p] && headReady[p];

    // A header leaving now does not request again.
    assign isHead[p] = headValid[p] && (headFlit[p].flitKind == HEAD) && !xfer[p];

    grantTimer timer_i (
      .clk      (clk),
      .rst      (rst),
      .load     (xfer[p] && (headFlit[p].flitKind == HEAD)),
      .length   (headFlit[p].length),
      .step     (xfer[p]),
      .lastFlit (lastFlit[p])
    );
  end

  assign packetDone = grantValid && lastFlit[grantPort];

  // Rotating search, starting after the last served port.
  always_comb
  begin : search
    int idx;
    found = 1'b0;
    pick  = lastServed;
    for (int i = 1; i <= `ROUTER_PORTS; i++)
    begin
      idx = (int'(lastServed) + i) % `ROUTER_PORTS;
      if (!found && isHead[idx])
      begin
        found = 1'b1;
        pick  = portIdx_t'(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= ARB_IDLE;
      lastServed <= portIdx_t'(`ROUTER_PORTS - 1);  // So Local comes first.
    end
    else if ((state == ARB_IDLE) || packetDone)
    begin
      if (found)
      begin
        state      <= ARB_BUSY;
        lastServed <= pick;
      end
      else
        state <= ARB_IDLE;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/switchStage.sv ====
`default_nettype none

`include "router_defines.svh"

module switchStage (
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::flit_t         headFlit [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0] headValid,
  output logic [`ROUTER_PORTS-1:0] headReady,
  input  logic                     grantValid,
  input  routerPkg::portIdx_t      grantPort,
  output routerPkg::flit_t         outFlit,
  output routerPkg::portIdx_t      outSource,
  output logic                     outValid,
  input  logic                     outReady
);

  logic canLoad;
  logic take;

  // Register free when empty or drained this cycle.
  assign canLoad = !outValid || outReady;
  assign take    = grantValid && headValid[grantPort] && canLoad;

  always_comb
  begin
    headReady = '0;
    if (grantValid && canLoad)
      headReady[grantPort] = 1'b1;  // Granted FIFO only.
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      outFlit   <= headFlit[grantPort];
      outSource <= grantPort;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (take)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== rtl/outputPortTop.sv ====
`default_nettype none

`include "router_defines.svh"

module outputPortTop (
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::flit_t         inFlit [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0] inValid,
  output logic [`ROUTER_PORTS-1:0] inReady,
  output routerPkg::flit_t         outFlit,
  output routerPkg::portIdx_t      outSource,
  output logic                     outValid,
  input  logic                     outReady
);

  import routerPkg::*;

  flit_t                    headFlit [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0] headValid;
  logic [`ROUTER_PORTS-1:0] headReady;
  logic                     grantValid;
  portIdx_t                 grantPort;

  // One input buffer per port.
  for (genvar p = 0; p < `ROUTER_PORTS; p++)
  begin : genFifo
    flitFifo #(
      .payload_t (flit_t),
      .DEPTH     (`ROUTER_FIFO_DEPTH)
    ) fifo_i (
      .clk      (clk),
      .rst      (rst),
      .inData   (inFlit[p]),
      .inValid  (inValid[p]),
      .inReady  (inReady[p]),
      .outData  (headFlit[p]),
      .outValid (headValid[p]),
      .outReady (headReady[p])
    );
  end

  packetArbiter arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .headFlit   (headFlit),
    .headValid  (headValid),
    .headReady  (headReady),
    .grantValid (grantValid),
    .grantPort  (grantPort)
  );

  switchStage switch_i (
    .clk        (clk),
    .rst        (rst),
    .headFlit   (headFlit),
    .headValid  (headValid),
    .headReady  (headReady),
    .grantValid (grantValid),
    .grantPort  (grantPort),
    .outFlit    (outFlit),
    .outSource  (outSource),
    .outValid   (outValid),
    .outReady   (outReady)
  );

endmodule

`default_nettype wire

// ==== verification/tbScoreboard.sv ====
`default_nettype none

`include "router_defines.svh"

module tbScoreboard (
  input  logic                     clk,
  input  logic                     rst,
  input  routerPkg::flit_t         inFlit [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0] inValid,
  input  logic [`ROUTER_PORTS-1:0] inReady,
  input  routerPkg::flit_t         outFlit,
  input  routerPkg::portIdx_t      outSource,
  input  logic                     outValid,
  input  logic                     outReady,
  input  logic                     rrCheck,
  output logic                     error,
  output int                       pending
);

  timeunit 1ns;
  timeprecision 1ps;

  import routerPkg::*;

  flit_t    expQ [`ROUTER_PORTS][$];  // Accepted, not yet seen at the output.
  portIdx_t lastHead;
  portIdx_t curSrc;
  int       remain;                   // Flits still owed by the open packet.
  logic     flitErr = 1'b0;
  logic     stallErr = 1'b0;

  assign error = flitErr || stallErr;

  function automatic portIdx_t nextPort(input portIdx_t p);
    return (p == portIdx_t'(`ROUTER_PORTS - 1)) ? portIdx_t'(0) : p + 1'b1;
  endfunction

  always @(posedge clk)
  begin : check
    flit_t exp;
    int    src;
    int    total;
    if (rst)
    begin
      lastHead = portIdx_t'(`ROUTER_PORTS - 1);
      curSrc   = '0;
      remain   = 0;
    end
    else
    begin
      for (int p = 0; p < `ROUTER_PORTS; p++)
        if (inValid[p] && inReady[p])
          expQ[p].push_back(inFlit[p]);
      if (outValid && outReady)
      begin
        src = int'(outSource);
        assert (src < `ROUTER_PORTS && expQ[src].size() != 0)
        else
        begin
          $display("Output flit from port %0d has no matching input flit", src);
          flitErr = 1'b1;
        end
        if (src < `ROUTER_PORTS && expQ[src].size() != 0)
        begin
          exp = expQ[src].pop_front();
          assert (outFlit == exp)
          else
          begin
            $display("[FAIL] outFlit (port %0d) expected %h got %h", src, exp, outFlit);
            flitErr = 1'b1;
          end
        end
        if (outFlit.flitKind == HEAD)
        begin
          assert (remain == 0)
          else
          begin
            $display("Header from port %0d cut into the packet of port %0d", src, curSrc);
            flitErr = 1'b1;
          end
          if (rrCheck)
          begin
            assert (outSource == nextPort(lastHead))
            else
            begin
              $display("[FAIL] outSource expected %h got %h", nextPort(lastHead), outSource);
              flitErr = 1'b1;
            end
          end
          lastHead = outSource;
          curSrc   = outSource;
          remain   = (outFlit.length == 0) ? 0 : int'(outFlit.length) - 1;  // Zero means one.
        end
        else
        begin
          assert (remain > 0)
          else
          begin
            $display("Flit from port %0d arrived outside any packet", src);
            flitErr = 1'b1;
          end
          assert (outSource == curSrc)
          else
          begin
            $display("[FAIL] outSource expected %h got %h", curSrc, outSource);
            flitErr = 1'b1;
          end
          remain = remain - 1;
        end
      end
    end
    total = 0;
    for (int p = 0; p < `ROUTER_PORTS; p++)
      total = total + expQ[p].size();
    pending = total;
  end

  // Output register holds while the sink stalls.
  holdOnStall: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outFlit) && $stable(outSource)))
  else
  begin
    $display("Output flit changed or vanished while outReady was low");
    stallErr = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/tbOutputPort.sv ====
`default_nettype none

`include "router_defines.svh"

module tbOutputPort;

  timeunit 1ns;
  timeprecision 1ps;

  import routerPkg::*;

  localparam int PORTS        = `ROUTER_PORTS;
  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 2000;
  localparam int STALL_LIMIT  = 20000;

  logic             clk;
  logic             rst;
  flit_t            inFlit [PORTS];
  logic [PORTS-1:0] inValid;
  logic [PORTS-1:0] inReady;
  flit_t            outFlit;
  portIdx_t         outSource;
  logic             outValid;
  logic             outReady;
  logic             rrCheck;
  logic             sbError;
  logic             genBusy;
  int               pending;
  int               stallCount = 0;  // Cycles a port was held off.
  logic [31:0]      rngState = 32'd55852;

  outputPortTop dut_i (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .inReady   (inReady),
    .outFlit   (outFlit),
    .outSource (outSource),
    .outValid  (outValid),
    .outReady  (outReady)
  );

  tbScoreboard scoreboard_i (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .inReady   (inReady),
    .outFlit   (outFlit),
    .outSource (outSource),
    .outValid  (outValid),
    .outReady  (outReady),
    .rrCheck   (rrCheck),
    .error     (sbError),
    .pending   (pending)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (!rst)
      stallCount <= stallCount + $countones(inValid & ~inReady);
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic flit_t makeFlit(input flitKind_t kind,
                                     input logic [`ROUTER_LEN_W-1:0] len,
                                     input logic [`ROUTER_DATA_W-1:0] data);
    flit_t f;
    f.flitKind = kind;
    f.length   = len;
    f.data     = data;
    return f;
  endfunction

  task automatic stopRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped on the first error.");
  endtask

  always @(posedge sbError)
  begin
    $display("Scoreboard check failed at %0t ns", $time);
    stopRun();
  end

  // Returns on the rising edge that accepts the flit.
  task automatic sendFlit(input int port, input flit_t f);
    int waited = 0;
    @(negedge clk);
    inFlit[port]  = f;
    inValid[port] = 1'b1;
    do
    begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        $display("Timeout: port %0d never accepted a flit", port);
        stopRun();
      end
    end
    while (!inReady[port]);
  endtask

  task automatic sendPacket(input int port, input int len, input logic zeroLen);
    logic [31:0]              r;
    flitKind_t                kind;
    logic [`ROUTER_LEN_W-1:0] lenField;
    for (int i = 0; i < len; i++)
    begin
      r = nextRand();
      if (i == 0)
      begin
        kind     = HEAD;
        lenField = (zeroLen && len == 1) ? '0 : `ROUTER_LEN_W'(len);
      end
      else
      begin
        kind     = (i == len - 1) ? TAIL : BODY;
        lenField = `ROUTER_LEN_W'(r >> 16);  // Junk, only the header counts.
      end
      sendFlit(port, makeFlit(kind, lenField, `ROUTER_DATA_W'(r)));
    end
  endtask

  task automatic sendStream(input int port, input int count, input logic gaps);
    logic [31:0] r;
    int          len;
    int          gap;
    for (int k = 0; k < count; k++)
    begin
      r   = nextRand();
      len = 1 + int'(r[7:0] % 8'd6);
      gap = gaps ? int'(r[9:8]) : 0;
      sendPacket(port, len, r[10]);
      if (gap > 0)
      begin
        @(negedge clk);
        inValid[port] = 1'b0;
        repeat (gap - 1) @(negedge clk);
      end
    end
    @(negedge clk);
    inValid[port] = 1'b0;
  endtask

  task automatic runAllPorts(input int count, input logic gaps);
    fork
      sendStream(0, count, gaps);
      sendStream(1, count, gaps);
      sendStream(2, count, gaps);
      sendStream(3, count, gaps);
      sendStream(4, count, gaps);
    join
  endtask

  task automatic driveStalls();
    logic [31:0] r;
    int          cycles = 0;
    while (genBusy)
    begin
      @(negedge clk);
      r        = nextRand();
      outReady = r[0];
      cycles++;
      if (cycles > STALL_LIMIT)
      begin
        $display("Timeout: injection under back-pressure never finished");
        stopRun();
      end
    end
    outReady = 1'b1;
  endtask

  task automatic waitDrain();
    int waited = 0;
    while (pending != 0 || outValid)
    begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        $display("Timeout: %0d accepted flits never left the output port", pending);
        stopRun();
      end
    end
  endtask

  initial
  begin
    int stallBase;
    rst      = 1'b1;
    outReady = 1'b1;
    rrCheck  = 1'b0;
    genBusy  = 1'b0;
    inValid  = '0;
    for (int p = 0; p < PORTS; p++)
      inFlit[p] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (outValid == 1'b0)
    else
    begin
      $display("[FAIL] outValid expected %h got %h", 1'b0, outValid);
      stopRun();
    end
    assert (inReady == '1)
    else
    begin
      $display("[FAIL] inReady expected %h got %h", {PORTS{1'b1}}, inReady);
      stopRun();
    end

    // Lone header from South into an idle arbiter.
    sendFlit(4, makeFlit(HEAD, `ROUTER_LEN_W'(1), `ROUTER_DATA_W'(16'hA5C3)));
    for (int c = 1; c <= 3; c++)
    begin
      @(negedge clk);
      if (c == 1)
        inValid[4] = 1'b0;
      assert (outValid == (c == 3))
      else
      begin
        $display("[FAIL] outValid expected %h got %h, %0d cycles after acceptance",
                 c == 3, outValid, c);
        stopRun();
      end
    end
    waitDrain();

    // All ports loaded, no stalls.
    @(negedge clk);
    rrCheck = 1'b1;
    runAllPorts(3, 1'b0);
    waitDrain();
    rrCheck = 1'b0;

    stallBase = stallCount;
    genBusy   = 1'b1;
    fork
      begin
        runAllPorts(4, 1'b1);
        genBusy = 1'b0;
      end
      driveStalls();
    join
    waitDrain();
    assert (stallCount > stallBase)
    else
    begin
      $display("inReady never dropped while the output was stalled");
      stopRun();
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/routerPkg.sv
rtl/flitFifo.sv
arbiter/grantTimer.sv
arbiter/packetArbiter.sv
rtl/switchStage.sv
rtl/outputPortTop.sv
verification/tbScoreboard.sv
verification/tbOutputPort.sv

// ==== Makefile ====
# Verilator build for the output-port testbench.

VERILATOR ?= verilator
TOP       ?= tbOutputPort
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := common/router_defines.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The binary exits non-zero on $fatal, so make reports the failure.
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
